// ==== rtl/core_pkg.sv ====
// widths, reset values and encodings for the pipeline core
// decoded control struct shared by decoder and stage registers
package core_pkg;

  // ====================
  // sizes
  // ====================
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  localparam logic [xlen-1:0] pc_step  = 32'd4;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // ====================
  // encodings
  // ====================
  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_lui    = 7'b0110111
  } opcode_e;

  // alu_add must stay zero so a bubble decodes to add
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_sll = 4'd6,
    alu_srl = 4'd7
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_imm} wb_sel_e;

  typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;

  typedef enum logic [1:0] {ctl_push, ctl_hold, ctl_flush} stage_ctl_e;

  // decoded control, all zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_en;
    logic    mem_write;
    logic    alu_imm;
    alu_op_e alu_op;
    wb_sel_e wb_sel;
    logic    branch;
    logic    branch_ne;
    logic    jump;
  } ctrl_t;

endpackage

// ==== rtl/hazard_if.sv ====
// pipeline to hazard unit signals
// register addresses and write flags in, forward selects and stage actions out
`timescale 1ns/1ps

interface hazard_if;

  logic [core_pkg::reg_addr_w-1:0] rs1_id, rs2_id, rs1_ex, rs2_ex;
  logic [core_pkg::reg_addr_w-1:0] rd_ex, rd_mem, rd_wb;
  logic                            wr_ex, wr_mem, wr_wb;
  logic                            load_ex, load_mem;
  logic                            branch_id, redirect, stall;

  core_pkg::fwd_sel_e   fwd_a_id, fwd_b_id, fwd_a_ex, fwd_b_ex;
  core_pkg::stage_ctl_e ctl_ifid, ctl_idex, ctl_exmem, ctl_memwb;
  logic                 pc_hold;

  modport pipe (
    output rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb,
    output wr_ex, wr_mem, wr_wb, load_ex, load_mem, branch_id, redirect, stall,
    input  fwd_a_id, fwd_b_id, fwd_a_ex, fwd_b_ex,
    input  ctl_ifid, ctl_idex, ctl_exmem, ctl_memwb, pc_hold
  );

  modport unit (
    input  rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb,
    input  wr_ex, wr_mem, wr_wb, load_ex, load_mem, branch_id, redirect, stall,
    output fwd_a_id, fwd_b_id, fwd_a_ex, fwd_b_ex,
    output ctl_ifid, ctl_idex, ctl_exmem, ctl_memwb, pc_hold
  );

endinterface

// ==== rtl/decoder.sv ====
// instruction decoder for the kept RV32I subset
// register fields, sign-extended immediate and control struct
`timescale 1ns/1ps

module decoder (
  input  logic [core_pkg::xlen-1:0]       instr,
  output logic [core_pkg::reg_addr_w-1:0] rs1,
  output logic [core_pkg::reg_addr_w-1:0] rs2,
  output logic [core_pkg::reg_addr_w-1:0] rd,
  output logic [core_pkg::xlen-1:0]       imm,
  output core_pkg::ctrl_t                 ctrl
);

  core_pkg::opcode_e opcode;
  core_pkg::ctrl_t   dec;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              valid;
  logic              use_rs1;
  logic              use_rs2;

  assign opcode = core_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate by format, I-type otherwise
  always_comb begin
    case (opcode)
      core_pkg::op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      core_pkg::op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
      core_pkg::op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
      core_pkg::op_lui:    imm = {instr[31:12], 12'h000};
      default:             imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    dec     = '0;
    valid   = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      core_pkg::op_reg: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        dec.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = core_pkg::alu_add;
          {7'h20, 3'b000}: dec.alu_op = core_pkg::alu_sub;
          {7'h00, 3'b111}: dec.alu_op = core_pkg::alu_and;
          {7'h00, 3'b110}: dec.alu_op = core_pkg::alu_or;
          {7'h00, 3'b100}: dec.alu_op = core_pkg::alu_xor;
          {7'h00, 3'b010}: dec.alu_op = core_pkg::alu_slt;
          {7'h00, 3'b001}: dec.alu_op = core_pkg::alu_sll;
          {7'h00, 3'b101}: dec.alu_op = core_pkg::alu_srl;
          default:         valid      = 1'b0;
        endcase
      end
      core_pkg::op_imm: begin
        use_rs1       = 1'b1;
        dec.reg_write = 1'b1;
        dec.alu_imm   = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = core_pkg::alu_add;
          3'b111:  dec.alu_op = core_pkg::alu_and;
          3'b110:  dec.alu_op = core_pkg::alu_or;
          3'b100:  dec.alu_op = core_pkg::alu_xor;
          3'b010:  dec.alu_op = core_pkg::alu_slt;
          default: valid      = 1'b0;
        endcase
      end
      core_pkg::op_load: begin
        valid         = (funct3 == 3'b010);
        use_rs1       = 1'b1;
        dec.reg_write = 1'b1;
        dec.mem_en    = 1'b1;
        dec.alu_imm   = 1'b1;
        dec.wb_sel    = core_pkg::wb_mem;
      end
      core_pkg::op_store: begin
        valid         = (funct3 == 3'b010);
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        dec.mem_en    = 1'b1;
        dec.mem_write = 1'b1;
        dec.alu_imm   = 1'b1;
      end
      core_pkg::op_branch: begin
        // beq and bne only
        valid         = (funct3[2:1] == 2'b00);
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        dec.branch    = 1'b1;
        dec.branch_ne = funct3[0];
      end
      core_pkg::op_jal: begin
        dec.reg_write = 1'b1;
        dec.jump      = 1'b1;
        dec.wb_sel    = core_pkg::wb_pc4;
      end
      core_pkg::op_lui: begin
        dec.reg_write = 1'b1;
        dec.wb_sel    = core_pkg::wb_imm;
      end
      default: valid = 1'b0;
    endcase
  end

  // unused fields read as x0 so they never raise a false hazard
  assign ctrl = valid ? dec : '0;
  assign rs1  = (valid && use_rs1) ? instr[19:15] : '0;
  assign rs2  = (valid && use_rs2) ? instr[24:20] : '0;
  assign rd   = (valid && dec.reg_write) ? instr[11:7] : '0;

endmodule

// ==== rtl/regfile.sv ====
// 32-entry integer register file, x0 reads as zero
// two read ports with write-through, one write port
`timescale 1ns/1ps

module regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wr_en,
  input  logic [core_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [core_pkg::xlen-1:0]       wr_data,
  input  logic [core_pkg::reg_addr_w-1:0] rd_addr1,
  input  logic [core_pkg::reg_addr_w-1:0] rd_addr2,
  output logic [core_pkg::xlen-1:0]       rd_data1,
  output logic [core_pkg::xlen-1:0]       rd_data2
);

  logic [core_pkg::xlen-1:0] regs [core_pkg::reg_count];
  logic                      wr_live;

  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // same-cycle write bypass
  assign rd_data1 = (wr_live && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
  assign rd_data2 = (wr_live && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

// ==== rtl/alu.sv ====
// integer ALU for the kept operations
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e         op,
  input  logic [core_pkg::xlen-1:0] a,
  input  logic [core_pkg::xlen-1:0] b,
  output logic [core_pkg::xlen-1:0] y
);

  logic [4:0] shamt;
  logic       less;

  assign shamt = b[4:0];
  // signed compare for slt and slti
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      core_pkg::alu_add: y = a + b;
      core_pkg::alu_sub: y = a - b;
      core_pkg::alu_and: y = a & b;
      core_pkg::alu_or:  y = a | b;
      core_pkg::alu_xor: y = a ^ b;
      core_pkg::alu_slt: y = {{(core_pkg::xlen-1){1'b0}}, less};
      core_pkg::alu_sll: y = a << shamt;
      core_pkg::alu_srl: y = a >> shamt;
      default:           y = a + b;
    endcase
  end

endmodule

// ==== rtl/hazard_unit.sv ====
// forwarding selects, load-use and branch bubbles
// per-stage push/hold/flush actions and pc hold
`timescale 1ns/1ps

module hazard_unit (
  input logic    rst,
  hazard_if.unit hz
);

  logic load_use;
  logic branch_dep;
  logic bubble;
  logic taken;

  // nonzero destination being written that matches the source
  function automatic logic hit(
    input logic [core_pkg::reg_addr_w-1:0] src,
    input logic [core_pkg::reg_addr_w-1:0] dst,
    input logic                            en
  );
    return en && (dst != '0) && (src == dst);
  endfunction

  // memory stage wins over writeback, being the younger result
  function automatic core_pkg::fwd_sel_e pick(
    input logic [core_pkg::reg_addr_w-1:0] src,
    input logic [core_pkg::reg_addr_w-1:0] rd_mem,
    input logic                            wr_mem,
    input logic [core_pkg::reg_addr_w-1:0] rd_wb,
    input logic                            wr_wb
  );
    if (hit(src, rd_mem, wr_mem)) begin
      return core_pkg::fwd_mem;
    end
    if (hit(src, rd_wb, wr_wb)) begin
      return core_pkg::fwd_wb;
    end
    return core_pkg::fwd_reg;
  endfunction

  assign hz.fwd_a_id = pick(hz.rs1_id, hz.rd_mem, hz.wr_mem, hz.rd_wb, hz.wr_wb);
  assign hz.fwd_b_id = pick(hz.rs2_id, hz.rd_mem, hz.wr_mem, hz.rd_wb, hz.wr_wb);
  assign hz.fwd_a_ex = pick(hz.rs1_ex, hz.rd_mem, hz.wr_mem, hz.rd_wb, hz.wr_wb);
  assign hz.fwd_b_ex = pick(hz.rs2_ex, hz.rd_mem, hz.wr_mem, hz.rd_wb, hz.wr_wb);

  assign load_use = hit(hz.rs1_id, hz.rd_ex, hz.load_ex) ||
                    hit(hz.rs2_id, hz.rd_ex, hz.load_ex);

  // compare in decode needs results not yet forwardable
  assign branch_dep = hz.branch_id &&
                      (hit(hz.rs1_id, hz.rd_ex, hz.wr_ex) ||
                       hit(hz.rs2_id, hz.rd_ex, hz.wr_ex) ||
                       hit(hz.rs1_id, hz.rd_mem, hz.load_mem) ||
                       hit(hz.rs2_id, hz.rd_mem, hz.load_mem));

  assign bubble = load_use || branch_dep;
  // a redirect counts only once its operands are valid
  assign taken  = hz.redirect && !bubble;

  always_comb begin
    hz.ctl_ifid  = core_pkg::ctl_push;
    hz.ctl_idex  = core_pkg::ctl_push;
    hz.ctl_exmem = core_pkg::ctl_push;
    hz.ctl_memwb = core_pkg::ctl_push;
    hz.pc_hold   = 1'b0;
    if (rst) begin
      hz.ctl_ifid  = core_pkg::ctl_flush;
      hz.ctl_idex  = core_pkg::ctl_flush;
      hz.ctl_exmem = core_pkg::ctl_flush;
      hz.ctl_memwb = core_pkg::ctl_flush;
    end else if (hz.stall) begin
      hz.ctl_ifid  = core_pkg::ctl_hold;
      hz.ctl_idex  = core_pkg::ctl_hold;
      hz.ctl_exmem = core_pkg::ctl_hold;
      hz.ctl_memwb = core_pkg::ctl_hold;
      hz.pc_hold   = 1'b1;
    end else if (taken) begin
      hz.ctl_ifid = core_pkg::ctl_flush;
    end else if (bubble) begin
      hz.ctl_ifid = core_pkg::ctl_hold;
      hz.ctl_idex = core_pkg::ctl_flush;
      hz.pc_hold  = 1'b1;
    end
  end

endmodule

// ==== rtl/core.sv ====
// five-stage in-order RV32I pipeline core
// PC, stage registers, operand forwarding, branch resolution in decode
// writeback select and the memory-side ports
`timescale 1ns/1ps

module core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stall,
  input  logic [core_pkg::xlen-1:0] im_data,
  input  logic [core_pkg::xlen-1:0] dm_rdata,
  output logic [core_pkg::xlen-1:0] im_addr,
  output logic                      dm_en,
  output logic                      dm_write,
  output logic [core_pkg::xlen-1:0] dm_addr,
  output logic [core_pkg::xlen-1:0] dm_wdata
);

  hazard_if hz ();

  logic [core_pkg::xlen-1:0]       pc;
  // decode
  logic [core_pkg::xlen-1:0]       instr_id, pc_id, imm_id, rf_a, rf_b, opa_id, opb_id;
  logic [core_pkg::xlen-1:0]       target;
  logic [core_pkg::reg_addr_w-1:0] rs1_id, rs2_id, rd_id;
  core_pkg::ctrl_t                 ctrl_id;
  logic                            taken;
  // execute
  logic [core_pkg::xlen-1:0]       opa_ex, opb_ex, imm_ex, pc4_ex;
  logic [core_pkg::xlen-1:0]       opa_fw, opb_fw, alu_b, alu_y;
  logic [core_pkg::reg_addr_w-1:0] rs1_ex, rs2_ex, rd_ex;
  core_pkg::ctrl_t                 ctrl_ex;
  // memory
  logic [core_pkg::xlen-1:0]       alu_mem, store_mem, imm_mem, pc4_mem, mem_val;
  logic [core_pkg::reg_addr_w-1:0] rd_mem;
  core_pkg::ctrl_t                 ctrl_mem;
  // writeback
  logic [core_pkg::xlen-1:0]       res_wb, load_wb, wb_val;
  logic [core_pkg::reg_addr_w-1:0] rd_wb;
  core_pkg::ctrl_t                 ctrl_wb;

  function automatic logic [core_pkg::xlen-1:0] fwd_pick(
    input core_pkg::fwd_sel_e        sel,
    input logic [core_pkg::xlen-1:0] from_reg,
    input logic [core_pkg::xlen-1:0] from_mem,
    input logic [core_pkg::xlen-1:0] from_wb
  );
    case (sel)
      core_pkg::fwd_mem: return from_mem;
      core_pkg::fwd_wb:  return from_wb;
      default:           return from_reg;
    endcase
  endfunction

  // control half of a stage register
  function automatic core_pkg::ctrl_t next_ctrl(
    input core_pkg::stage_ctl_e ctl,
    input core_pkg::ctrl_t      cur,
    input core_pkg::ctrl_t      nxt
  );
    case (ctl)
      core_pkg::ctl_flush: return '0;
      core_pkg::ctl_hold:  return cur;
      default:             return nxt;
    endcase
  endfunction

  // ====================
  // fetch
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= core_pkg::reset_pc;
    end else if (!hz.pc_hold) begin
      pc <= taken ? target : pc + core_pkg::pc_step;
    end
  end

  assign im_addr = pc;

  // a zero word decodes as a bubble
  always_ff @(posedge clk) begin
    case (hz.ctl_ifid)
      core_pkg::ctl_flush: instr_id <= '0;
      core_pkg::ctl_push:  instr_id <= im_data;
      default:             instr_id <= instr_id;
    endcase
    if (hz.ctl_ifid != core_pkg::ctl_hold) begin
      pc_id <= pc;
    end
  end

  // ====================
  // decode
  // ====================
  decoder u_decoder (
    .instr (instr_id),
    .rs1   (rs1_id),
    .rs2   (rs2_id),
    .rd    (rd_id),
    .imm   (imm_id),
    .ctrl  (ctrl_id)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (ctrl_wb.reg_write),
    .wr_addr  (rd_wb),
    .wr_data  (wb_val),
    .rd_addr1 (rs1_id),
    .rd_addr2 (rs2_id),
    .rd_data1 (rf_a),
    .rd_data2 (rf_b)
  );

  // writeback results reach decode through the register file bypass
  assign opa_id = (hz.fwd_a_id == core_pkg::fwd_mem) ? mem_val : rf_a;
  assign opb_id = (hz.fwd_b_id == core_pkg::fwd_mem) ? mem_val : rf_b;

  // beq/bne compare and jal, both targets are pc relative
  assign taken  = ctrl_id.jump ||
                  (ctrl_id.branch && ((opa_id == opb_id) ^ ctrl_id.branch_ne));
  assign target = pc_id + imm_id;

  always_ff @(posedge clk) begin
    ctrl_ex <= next_ctrl(hz.ctl_idex, ctrl_ex, ctrl_id);
    if (hz.ctl_idex != core_pkg::ctl_hold) begin
      rs1_ex <= rs1_id;
      rs2_ex <= rs2_id;
      rd_ex  <= rd_id;
      opa_ex <= opa_id;
      opb_ex <= opb_id;
      imm_ex <= imm_id;
      pc4_ex <= pc_id + core_pkg::pc_step;
    end
  end

  // ====================
  // execute
  // ====================
  assign opa_fw = fwd_pick(hz.fwd_a_ex, opa_ex, mem_val, wb_val);
  assign opb_fw = fwd_pick(hz.fwd_b_ex, opb_ex, mem_val, wb_val);
  assign alu_b  = ctrl_ex.alu_imm ? imm_ex : opb_fw;

  alu u_alu (
    .op (ctrl_ex.alu_op),
    .a  (opa_fw),
    .b  (alu_b),
    .y  (alu_y)
  );

  always_ff @(posedge clk) begin
    ctrl_mem <= next_ctrl(hz.ctl_exmem, ctrl_mem, ctrl_ex);
    if (hz.ctl_exmem != core_pkg::ctl_hold) begin
      rd_mem    <= rd_ex;
      alu_mem   <= alu_y;
      store_mem <= opb_fw;
      imm_mem   <= imm_ex;
      pc4_mem   <= pc4_ex;
    end
  end

  // ====================
  // memory
  // ====================
  // load data is not forwarded from here, the hazard unit bubbles instead
  always_comb begin
    case (ctrl_mem.wb_sel)
      core_pkg::wb_pc4: mem_val = pc4_mem;
      core_pkg::wb_imm: mem_val = imm_mem;
      default:          mem_val = alu_mem;
    endcase
  end

  assign dm_en    = ctrl_mem.mem_en;
  assign dm_write = ctrl_mem.mem_write;
  assign dm_addr  = alu_mem;
  assign dm_wdata = store_mem;

  always_ff @(posedge clk) begin
    ctrl_wb <= next_ctrl(hz.ctl_memwb, ctrl_wb, ctrl_mem);
    if (hz.ctl_memwb != core_pkg::ctl_hold) begin
      rd_wb   <= rd_mem;
      res_wb  <= mem_val;
      load_wb <= dm_rdata;
    end
  end

  // ====================
  // writeback
  // ====================
  assign wb_val = (ctrl_wb.wb_sel == core_pkg::wb_mem) ? load_wb : res_wb;

  // hazard unit hookup
  assign hz.rs1_id    = rs1_id;
  assign hz.rs2_id    = rs2_id;
  assign hz.rs1_ex    = rs1_ex;
  assign hz.rs2_ex    = rs2_ex;
  assign hz.rd_ex     = rd_ex;
  assign hz.rd_mem    = rd_mem;
  assign hz.rd_wb     = rd_wb;
  assign hz.wr_ex     = ctrl_ex.reg_write;
  assign hz.wr_mem    = ctrl_mem.reg_write;
  assign hz.wr_wb     = ctrl_wb.reg_write;
  assign hz.load_ex   = ctrl_ex.mem_en && !ctrl_ex.mem_write;
  assign hz.load_mem  = ctrl_mem.mem_en && !ctrl_mem.mem_write;
  assign hz.branch_id = ctrl_id.branch || ctrl_id.jump;
  assign hz.redirect  = taken;
  assign hz.stall     = stall;

  hazard_unit u_hazard (
    .rst (rst),
    .hz  (hz.unit)
  );

endmodule

// ==== verification/tb_program.svh ====
// test program for the pipeline core as an instruction table
// expected stores by address, with the marker address of skipped code
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int          prog_len    = 36;
localparam int          n_stores    = 7;
localparam logic [31:0] poison_addr = 32'h0000_0100;

logic [31:0] exp_addr [n_stores];
logic [31:0] exp_data [n_stores];
string       test_name [n_stores];

function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
endfunction

function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::op_store};
endfunction

function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::op_branch};
endfunction

function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::op_jal};
endfunction

task automatic load_program();
  // dependent alu chain, x1..x15
  imem[0]  = {20'h12345, 5'd1, core_pkg::op_lui};
  imem[1]  = itype(12'h0ff, 5'd0, 3'b000, 5'd2, core_pkg::op_imm);
  imem[2]  = rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
  imem[3]  = rtype(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
  imem[4]  = rtype(7'h00, 5'd3, 5'd4, 3'b100, 5'd5);
  imem[5]  = rtype(7'h00, 5'd1, 5'd5, 3'b110, 5'd6);
  imem[6]  = rtype(7'h00, 5'd2, 5'd6, 3'b111, 5'd7);
  imem[7]  = rtype(7'h00, 5'd7, 5'd0, 3'b010, 5'd8);
  imem[8]  = rtype(7'h00, 5'd8, 5'd7, 3'b001, 5'd9);
  imem[9]  = rtype(7'h00, 5'd8, 5'd9, 3'b101, 5'd10);
  imem[10] = itype(12'h00f, 5'd10, 3'b111, 5'd11, core_pkg::op_imm);
  imem[11] = itype(12'h030, 5'd11, 3'b110, 5'd12, core_pkg::op_imm);
  imem[12] = itype(12'h7ff, 5'd12, 3'b100, 5'd13, core_pkg::op_imm);
  imem[13] = itype(12'h7ff, 5'd13, 3'b010, 5'd14, core_pkg::op_imm);
  imem[14] = rtype(7'h00, 5'd14, 5'd13, 3'b000, 5'd15);
  imem[15] = stype(12'h200, 5'd15, 5'd0);
  imem[16] = stype(12'h204, 5'd9, 5'd0);
  imem[17] = stype(12'h208, 5'd3, 5'd0);
  // load-use
  imem[18] = itype(12'h200, 5'd0, 3'b010, 5'd16, core_pkg::op_load);
  imem[19] = rtype(7'h00, 5'd2, 5'd16, 3'b000, 5'd17);
  imem[20] = stype(12'h20c, 5'd17, 5'd0);
  // beq taken, bne not taken, jal with link
  imem[21] = btype(13'd8, 5'd10, 5'd2, 3'b000);
  imem[22] = stype(poison_addr[11:0], 5'd1, 5'd0);
  imem[23] = btype(13'd8, 5'd10, 5'd2, 3'b001);
  imem[24] = stype(12'h210, 5'd2, 5'd0);
  imem[25] = jtype(21'd8, 5'd18);
  imem[26] = stype(poison_addr[11:0], 5'd1, 5'd0);
  imem[27] = stype(12'h214, 5'd18, 5'd0);
  // branches right after their producer
  imem[28] = itype(12'h005, 5'd0, 3'b000, 5'd19, core_pkg::op_imm);
  imem[29] = btype(13'd8, 5'd0, 5'd19, 3'b001);
  imem[30] = stype(poison_addr[11:0], 5'd1, 5'd0);
  imem[31] = itype(12'h005, 5'd0, 3'b000, 5'd20, core_pkg::op_imm);
  imem[32] = btype(13'd8, 5'd19, 5'd20, 3'b000);
  imem[33] = stype(poison_addr[11:0], 5'd1, 5'd0);
  imem[34] = stype(12'h218, 5'd19, 5'd0);
  // park on a self loop
  imem[35] = jtype(21'd0, 5'd0);

  exp_addr[0]  = 32'h200;
  exp_data[0]  = 32'h0000_07c1;
  test_name[0] = "alu_imm_chain";
  exp_addr[1]  = 32'h204;
  exp_data[1]  = 32'h0000_01fe;
  test_name[1] = "shift_slt";
  exp_addr[2]  = 32'h208;
  exp_data[2]  = 32'h1234_50ff;
  test_name[2] = "lui_forwarding";
  exp_addr[3]  = 32'h20c;
  exp_data[3]  = 32'h0000_08c0;
  test_name[3] = "load_use";
  exp_addr[4]  = 32'h210;
  exp_data[4]  = 32'h0000_00ff;
  test_name[4] = "branch_taken_not";
  exp_addr[5]  = 32'h214;
  exp_data[5]  = 32'h0000_0068;
  test_name[5] = "jal_link";
  exp_addr[6]  = 32'h218;
  exp_data[6]  = 32'h0000_0005;
  test_name[6] = "branch_after_producer";
endtask

`endif

// ==== verification/core_tb.sv ====
// testbench for the pipeline core
// memory models, random stall, concurrent checks, reporting and timeout
`timescale 1ns/1ps

module core_tb;

  logic        clk;
  logic        rst;
  logic        stall;
  logic [31:0] im_addr, im_data;
  logic        dm_en, dm_write;
  logic [31:0] dm_addr, dm_wdata, dm_rdata;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];

  `include "tb_program.svh"

  localparam int cycle_limit = 4 * prog_len + 200;

  int          seen [n_stores];
  logic [16:0] lfsr;
  logic [16:0] s1, s2;
  logic        rst_q;
  logic        held;
  logic [65:0] held_val;
  logic        store_now;
  int          errors;
  int          stores_seen;
  int          cycles;
  int          drain;
  int          idx;

  core u_core (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .im_data  (im_data),
    .dm_rdata (dm_rdata),
    .im_addr  (im_addr),
    .dm_en    (dm_en),
    .dm_write (dm_write),
    .dm_addr  (dm_addr),
    .dm_wdata (dm_wdata)
  );

  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  function automatic int store_index(input logic [31:0] a);
    for (int i = 0; i < n_stores; i++) begin
      if (exp_addr[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic finish_run();
    $display("stores %0d of %0d, errors %0d", stores_seen, n_stores, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // ====================
  // clock, reset, memories
  // ====================
  always #10 clk = ~clk;

  assign im_data   = imem[im_addr[9:2]];
  assign dm_rdata  = dmem[dm_addr[9:2]];
  assign store_now = dm_en && dm_write && !stall;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    stall = 1'b0;
    lfsr = 17'd81270;
    rst_q = 1'b0;
    held = 1'b0;
    held_val = '0;
    errors = 0;
    stores_seen = 0;
    cycles = 0;
    drain = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    for (int i = 0; i < n_stores; i++) begin
      seen[i] = 0;
    end
    load_program();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

  always @(posedge clk) begin
    if (store_now && !rst) begin
      dmem[dm_addr[9:2]] <= dm_wdata;
    end
  end

  // stall about one cycle in four, two lfsr bits per cycle
  always @(posedge clk) begin
    if (rst) begin
      stall <= 1'b0;
    end else begin
      s1 = lfsr_next(lfsr);
      s2 = lfsr_next(s1);
      lfsr <= s2;
      stall <= s1[0] & s2[0];
    end
  end

  always @(posedge clk) begin
    rst_q <= rst;
    held <= stall && !rst;
    held_val <= {dm_en, dm_write, dm_addr, dm_wdata};
  end

  // ====================
  // checks
  // ====================
  assert property (@(posedge clk) rst_q |-> !dm_en && !dm_write)
    else begin
      $display("[FAIL] dm_en/dm_write: expected 0/0, got %h/%h",
               $sampled(dm_en), $sampled(dm_write));
      errors++;
    end

  assert property (@(posedge clk) (!rst && rst_q) |-> im_addr == core_pkg::reset_pc)
    else begin
      $display("[FAIL] im_addr: expected %h, got %h", core_pkg::reset_pc, $sampled(im_addr));
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   held |-> {dm_en, dm_write, dm_addr, dm_wdata} == held_val)
    else begin
      $display("[FAIL] dm outputs under stall: expected %h, got %h", $sampled(held_val),
               $sampled({dm_en, dm_write, dm_addr, dm_wdata}));
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst) store_now |-> dm_addr != poison_addr)
    else begin
      $display("a skipped instruction stored to the marker address %h", poison_addr);
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   store_now |-> store_index(dm_addr) >= 0 || dm_addr == poison_addr)
    else begin
      $display("store to an address no test expects: %h", $sampled(dm_addr));
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   store_now && store_index(dm_addr) >= 0 |->
                   dm_wdata == exp_data[store_index(dm_addr)])
    else begin
      $display("[FAIL] dm_wdata at %h: expected %h, got %h", $sampled(dm_addr),
               exp_data[store_index($sampled(dm_addr))], $sampled(dm_wdata));
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   store_now && store_index(dm_addr) >= 0 |-> seen[store_index(dm_addr)] == 0)
    else begin
      $display("store to %h arrived more than once", $sampled(dm_addr));
      errors++;
    end

  // ====================
  // per-test lines and end of run
  // ====================
  always @(posedge clk) begin
    if (!rst && store_now) begin
      idx = store_index(dm_addr);
      if (idx >= 0) begin
        if (seen[idx] == 0) begin
          stores_seen <= stores_seen + 1;
          $display("test %s finished: store to %h with %h", test_name[idx], dm_addr,
                   dm_wdata);
        end
        seen[idx] <= seen[idx] + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (stores_seen == n_stores) begin
      drain <= drain + 1;
    end
    if (drain == 8) begin
      finish_run();
    end else if (cycles == cycle_limit) begin
      $display("timeout after %0d cycles", cycles);
      for (int i = 0; i < n_stores; i++) begin
        if (seen[i] == 0) begin
          $display("test %s never stored to %h", test_name[i], exp_addr[i]);
        end
      end
      errors++;
      finish_run();
    end
  end

endmodule

// ==== compile.f ====
+incdir+verification
rtl/core_pkg.sv
rtl/hazard_if.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/core.sv
verification/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module core_tb \
  --Mdir obj_dir -o core_sim > build.log 2>&1 \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
